/* include/glyph_table.svh */
//////////////////////////////////////////////////////////////////////
// Glyph bitmaps for the register display font
// Case items that load glyph_bits with the 8x8 bitmap of a glyph code
//////////////////////////////////////////////////////////////////////

// Row r sits in bits [8r+7:8r], bit 7 of a row is the leftmost column
8'd0:  glyph_bits = 64'h7CC2A2928A867C00;  // 0
8'd1:  glyph_bits = 64'hFE10101010507000;  // 1
8'd2:  glyph_bits = 64'h7C20100804847800;  // 2
8'd3:  glyph_bits = 64'hFC02023C0202FC00;  // 3
8'd4:  glyph_bits = 64'h080808FE88888800;  // 4
8'd5:  glyph_bits = 64'hFC0202FC8080FE00;  // 5
8'd6:  glyph_bits = 64'h7C8282FC80807C00;  // 6
8'd7:  glyph_bits = 64'h402010080402FE00;  // 7
8'd8:  glyph_bits = 64'h7C82827C82827C00;  // 8
8'd9:  glyph_bits = 64'h0202027E82827C00;  // 9
8'd10: glyph_bits = 64'h848484FC84847800;  // A
8'd11: glyph_bits = 64'hF88484F88888F000;  // B
8'd12: glyph_bits = 64'h7E80808080807E00;  // C
8'd13: glyph_bits = 64'hF88484848484F800;  // D
8'd14: glyph_bits = 64'hFE8080FC8080FE00;  // E
8'd15: glyph_bits = 64'h808080FC8080FE00;  // F
8'd16: glyph_bits = 64'h7C82828E80827C00;  // G
8'd18: glyph_bits = 64'h7C10101010107C00;  // I
8'd21: glyph_bits = 64'hFC80808080808000;  // L
8'd23: glyph_bits = 64'h82868A92A2C28200;  // N
8'd27: glyph_bits = 64'h848890F88484F800;  // R
8'd28: glyph_bits = 64'h788404047C807C00;  // S
8'd29: glyph_bits = 64'h202020202020FE00;  // T
8'd36: glyph_bits = 64'h0060600000606000;  // Colon
8'd37: glyph_bits = 64'h0000000000000000;  // Space

/* logic/disp_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Register display package
// Screen layout, colors, glyph codes and shared struct types
//////////////////////////////////////////////////////////////////////
`default_nettype none

package disp_pkg;

    localparam int NUM_REGS   = 8;
    localparam int REG_W      = 32;

    localparam int GLYPH_DIM  = 8;   // Glyph is square
    localparam int CHAR_PITCH = 9;   // One blank column between glyphs
    localparam int TITLE_LEN  = 16;
    localparam int LINE_LEN   = 12;  // "Rn: " plus eight hex digits
    localparam int REG_CHARS  = NUM_REGS * LINE_LEN;

    localparam int TITLE_X0   = 10;
    localparam int TITLE_Y0   = 10;
    localparam int TEXT_X0    = 10;
    localparam int TEXT_Y0    = 25;
    localparam int LINE_PITCH = 15;

    typedef logic [7:0] glyph_code_t;
    typedef logic [8:0] color_t;     // RRR GGG BBB

    localparam color_t TITLE_COLOR = 9'b111_111_111;
    localparam color_t TEXT_COLOR  = 9'b000_111_000;
    localparam color_t BG_COLOR    = 9'b000_000_000;

    // Hex digits use their own value as code
    localparam glyph_code_t GLYPH_HEX0  = 8'd0;
    localparam glyph_code_t GLYPH_A     = 8'd10;
    localparam glyph_code_t GLYPH_E     = 8'd14;
    localparam glyph_code_t GLYPH_G     = 8'd16;
    localparam glyph_code_t GLYPH_I     = 8'd18;
    localparam glyph_code_t GLYPH_L     = 8'd21;
    localparam glyph_code_t GLYPH_N     = 8'd23;
    localparam glyph_code_t GLYPH_R     = 8'd27;
    localparam glyph_code_t GLYPH_S     = 8'd28;
    localparam glyph_code_t GLYPH_T     = 8'd29;
    localparam glyph_code_t GLYPH_COLON = 8'd36;
    localparam glyph_code_t GLYPH_SPACE = 8'd37;

    typedef struct packed {
        logic [9:0] x;
        logic [8:0] y;
        color_t     color;
    } pixel_t;

    typedef struct packed {
        logic [6:0] char_idx;
        logic [2:0] pixel_x;
        logic [2:0] pixel_y;
    } scan_pos_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [4:0]  paddr;    // Byte address
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic        pslverr;
        logic [31:0] prdata;
    } apb_rsp_t;

    typedef enum logic {
        PHASE_TITLE,
        PHASE_REGS
    } draw_phase_t;

endpackage

`default_nettype wire

/* logic/reg_bank_apb.sv */
//////////////////////////////////////////////////////////////////////
// APB register bank holding the eight displayed registers
// Zero-wait slave, misaligned accesses answer with pslverr
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module reg_bank_apb (
    input  logic                                            clock,
    input  logic                                            resetn,
    input  disp_pkg::apb_req_t                              apb_req,
    output disp_pkg::apb_rsp_t                              apb_rsp,
    output logic [disp_pkg::NUM_REGS-1:0][disp_pkg::REG_W-1:0] regs
);
    import disp_pkg::*;

    logic       access;
    logic       aligned;
    logic       wr_en;
    logic [2:0] reg_sel;

    // Access phase of a selected transfer
    assign access  = apb_req.psel && apb_req.penable;
    assign aligned = (apb_req.paddr[1:0] == 2'b00);
    assign reg_sel = apb_req.paddr[4:2];  // Word index, always below 8
    assign wr_en   = access && apb_req.pwrite && aligned;

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            regs <= '0;
        end else if (wr_en) begin
            regs[reg_sel] <= apb_req.pwdata;
        end
    end

    // No wait states, response is purely combinational
    always_comb begin
        apb_rsp         = '0;
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access && !aligned;
        apb_rsp.prdata  = regs[reg_sel];
    end

endmodule

`default_nettype wire

/* logic/glyph_scan_counter.sv */
//////////////////////////////////////////////////////////////////////
// Glyph scan counter
// Steps pixel column, pixel row and character index per accepted pixel
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module glyph_scan_counter (
    input  logic                clock,
    input  logic                resetn,
    input  logic                advance,
    input  logic                char_clear,
    output disp_pkg::scan_pos_t scan,
    output logic                glyph_end
);
    import disp_pkg::*;

    logic col_last;
    logic row_last;

    assign col_last  = (scan.pixel_x == 3'(GLYPH_DIM - 1));
    assign row_last  = (scan.pixel_y == 3'(GLYPH_DIM - 1));
    assign glyph_end = col_last && row_last;  // Bottom right pixel of a glyph

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            scan <= '0;
        end else if (advance) begin
            if (!col_last) begin
                scan.pixel_x <= scan.pixel_x + 3'd1;
            end else begin
                scan.pixel_x <= '0;
                if (!row_last) begin
                    scan.pixel_y <= scan.pixel_y + 3'd1;
                end else begin
                    scan.pixel_y <= '0;
                    // Phase change restarts the character count
                    if (char_clear) begin
                        scan.char_idx <= '0;
                    end else begin
                        scan.char_idx <= scan.char_idx + 7'd1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/draw_sequencer.sv */
//////////////////////////////////////////////////////////////////////
// Draw sequencer
// Alternates title and register phases and flags the end of a frame
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module draw_sequencer (
    input  logic                  clock,
    input  logic                  resetn,
    input  logic                  advance,
    input  logic                  glyph_end,
    input  logic [6:0]            char_idx,
    output disp_pkg::draw_phase_t phase,
    output logic                  char_clear,
    output logic                  frame_done
);
    import disp_pkg::*;

    logic [6:0]  last_idx;
    draw_phase_t next_phase;

    // Last character index of the current phase
    assign last_idx   = (phase == PHASE_TITLE) ? 7'(TITLE_LEN - 1) : 7'(REG_CHARS - 1);
    assign char_clear = glyph_end && (char_idx == last_idx);
    assign frame_done = advance && char_clear && (phase == PHASE_REGS);

    always_comb begin
        next_phase = phase;
        if (advance && char_clear) begin
            case (phase)
                PHASE_TITLE: next_phase = PHASE_REGS;
                PHASE_REGS:  next_phase = PHASE_TITLE;  // New frame
                default:     next_phase = PHASE_TITLE;
            endcase
        end
    end

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            phase <= PHASE_TITLE;
        end else begin
            phase <= next_phase;
        end
    end

endmodule

`default_nettype wire

/* logic/text_layout.sv */
//////////////////////////////////////////////////////////////////////
// Text layout
// Picks the glyph and screen origin of the character being drawn
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module text_layout (
    input  disp_pkg::draw_phase_t                               phase,
    input  logic [6:0]                                          char_idx,
    input  logic [disp_pkg::NUM_REGS-1:0][disp_pkg::REG_W-1:0]  regs,
    output disp_pkg::glyph_code_t                               code,
    output logic [9:0]                                          origin_x,
    output logic [8:0]                                          origin_y
);
    import disp_pkg::*;

    logic [2:0]       line;
    logic [3:0]       col;
    logic [2:0]       nib_sel;
    logic [REG_W-1:0] line_reg;
    glyph_code_t      title_code;

    assign line     = 3'(char_idx / LINE_LEN);
    assign col      = 4'(char_idx % LINE_LEN);
    assign line_reg = regs[line];
    assign nib_sel  = 3'(LINE_LEN - 1 - col);  // Column 4 is the top nibble

    // "GENERAL REGISTER"
    always_comb begin
        case (char_idx[3:0])
            4'd0:    title_code = GLYPH_G;
            4'd1:    title_code = GLYPH_E;
            4'd2:    title_code = GLYPH_N;
            4'd3:    title_code = GLYPH_E;
            4'd4:    title_code = GLYPH_R;
            4'd5:    title_code = GLYPH_A;
            4'd6:    title_code = GLYPH_L;
            4'd8:    title_code = GLYPH_R;
            4'd9:    title_code = GLYPH_E;
            4'd10:   title_code = GLYPH_G;
            4'd11:   title_code = GLYPH_I;
            4'd12:   title_code = GLYPH_S;
            4'd13:   title_code = GLYPH_T;
            4'd14:   title_code = GLYPH_E;
            4'd15:   title_code = GLYPH_R;
            default: title_code = GLYPH_SPACE;
        endcase
    end

    always_comb begin
        if (phase == PHASE_TITLE) begin
            code     = title_code;
            origin_x = 10'(TITLE_X0 + char_idx * CHAR_PITCH);
            origin_y = 9'(TITLE_Y0);
        end else begin
            case (col)
                4'd0:    code = GLYPH_R;
                4'd1:    code = GLYPH_HEX0 + glyph_code_t'(line);  // Register number
                4'd2:    code = GLYPH_COLON;
                4'd3:    code = GLYPH_SPACE;
                default: code = GLYPH_HEX0 + glyph_code_t'(line_reg[nib_sel*4 +: 4]);
            endcase
            origin_x = 10'(TEXT_X0 + col * CHAR_PITCH);
            origin_y = 9'(TEXT_Y0 + line * LINE_PITCH);
        end
    end

endmodule

`default_nettype wire

/* logic/glyph_raster.sv */
//////////////////////////////////////////////////////////////////////
// Glyph raster
// Turns glyph code and scan position into a colored screen pixel
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module glyph_raster (
    input  disp_pkg::glyph_code_t code,
    input  disp_pkg::scan_pos_t   scan,
    input  disp_pkg::draw_phase_t phase,
    input  logic [9:0]            origin_x,
    input  logic [8:0]            origin_y,
    output disp_pkg::pixel_t      pix
);
    import disp_pkg::*;

    logic [GLYPH_DIM*GLYPH_DIM-1:0] glyph_bits;
    logic [GLYPH_DIM-1:0]           row_bits;
    logic                           bit_on;

    // Font ROM
    always_comb begin
        case (code)
            `include "glyph_table.svh"
            default: glyph_bits = '0;  // Unknown codes draw blank
        endcase
    end

    assign row_bits = glyph_bits[scan.pixel_y * GLYPH_DIM +: GLYPH_DIM];
    assign bit_on   = row_bits[3'(GLYPH_DIM - 1) - scan.pixel_x];  // MSB is leftmost

    always_comb begin
        pix.x = origin_x + 10'(scan.pixel_x);
        pix.y = origin_y + 9'(scan.pixel_y);
        if (!bit_on) begin
            pix.color = BG_COLOR;
        end else if (phase == PHASE_TITLE) begin
            pix.color = TITLE_COLOR;
        end else begin
            pix.color = TEXT_COLOR;
        end
    end

endmodule

`default_nettype wire

/* logic/reg_display_top.sv */
//////////////////////////////////////////////////////////////////////
// Register display top level
// APB register bank rendered as a stream of text pixels
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module reg_display_top (
    input  logic               clock,
    input  logic               resetn,
    input  disp_pkg::apb_req_t apb_req,
    output disp_pkg::apb_rsp_t apb_rsp,
    output disp_pkg::pixel_t   pix,
    output logic               pix_valid,
    input  logic               pix_ready,
    output logic               frame_done
);
    import disp_pkg::*;

    logic                           valid_q;
    logic                           advance;
    logic [NUM_REGS-1:0][REG_W-1:0] regs;
    scan_pos_t                      scan;
    logic                           glyph_end;
    draw_phase_t                    phase;
    logic                           char_clear;
    glyph_code_t                    code;
    logic [9:0]                     origin_x;
    logic [8:0]                     origin_y;

    // Stream runs continuously once out of reset
    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b1;
        end
    end

    assign pix_valid = valid_q;
    assign advance   = pix_valid && pix_ready;  // Pixel accepted

    reg_bank_apb u_bank (
        .clock   (clock),
        .resetn  (resetn),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .regs    (regs)
    );

    glyph_scan_counter u_scan (
        .clock      (clock),
        .resetn     (resetn),
        .advance    (advance),
        .char_clear (char_clear),
        .scan       (scan),
        .glyph_end  (glyph_end)
    );

    draw_sequencer u_seq (
        .clock      (clock),
        .resetn     (resetn),
        .advance    (advance),
        .glyph_end  (glyph_end),
        .char_idx   (scan.char_idx),
        .phase      (phase),
        .char_clear (char_clear),
        .frame_done (frame_done)
    );

    text_layout u_layout (
        .phase    (phase),
        .char_idx (scan.char_idx),
        .regs     (regs),
        .code     (code),
        .origin_x (origin_x),
        .origin_y (origin_y)
    );

    glyph_raster u_raster (
        .code     (code),
        .scan     (scan),
        .phase    (phase),
        .origin_x (origin_x),
        .origin_y (origin_y),
        .pix      (pix)
    );

endmodule

`default_nettype wire

/* testbench/reg_display_properties.sv */
//////////////////////////////////////////////////////////////////////
// Concurrent checks on the APB port and the pixel stream handshake
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module reg_display_properties (
    input logic               clock,
    input logic               resetn,
    input disp_pkg::apb_req_t apb_req,
    input disp_pkg::apb_rsp_t apb_rsp,
    input disp_pkg::pixel_t   pix,
    input logic               pix_valid,
    input logic               pix_ready,
    input logic               frame_done
);
    int prop_errors = 0;  // Read by the testbench at the end of the run

    // Stalled pixel must not move
    stall_hold: assert property (@(posedge clock) disable iff (!resetn)
        pix_valid && !pix_ready |=> $stable(pix))
        else begin
            prop_errors++;
            $error("pix changed while pix_ready was low");
        end

    valid_stays: assert property (@(posedge clock) disable iff (!resetn)
        pix_valid |=> pix_valid)
        else begin
            prop_errors++;
            $error("pix_valid dropped after going high");
        end

    zero_wait: assert property (@(posedge clock) disable iff (!resetn)
        apb_req.psel && apb_req.penable |-> apb_rsp.pready)
        else begin
            prop_errors++;
            $error("pready low in an APB access phase");
        end

    slverr_in_access: assert property (@(posedge clock) disable iff (!resetn)
        apb_rsp.pslverr |-> apb_req.psel && apb_req.penable)
        else begin
            prop_errors++;
            $error("pslverr high outside an APB access phase");
        end

    done_on_accept: assert property (@(posedge clock) disable iff (!resetn)
        frame_done |-> pix_valid && pix_ready)
        else begin
            prop_errors++;
            $error("frame_done high without an accepted pixel");
        end

endmodule

bind reg_display_top reg_display_properties u_props (
    .clock      (clock),
    .resetn     (resetn),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .pix        (pix),
    .pix_valid  (pix_valid),
    .pix_ready  (pix_ready),
    .frame_done (frame_done)
);

`default_nettype wire

/* testbench/reg_display_tb.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for the register display
// APB traffic, stalling pixel sink and pixel by pixel reference check
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module reg_display_tb;
    import disp_pkg::*;

    localparam int    FRAME_PIX       = (TITLE_LEN + REG_CHARS) * GLYPH_DIM * GLYPH_DIM;
    localparam int    WATCHDOG_CYCLES = 8 * FRAME_PIX + 1000;  // 3 frames at 3/4 rate, doubled
    localparam string TITLE_TEXT      = "GENERAL REGISTER";

    logic     clock;
    logic     resetn;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    pixel_t   pix;
    logic     pix_valid;
    logic     pix_ready;
    logic     frame_done;

    integer                         seed        = 99405;
    int                             pix_errors  = 0;
    int                             apb_errors  = 0;
    int                             acc_idx     = 0;  // Acceptances in the current frame
    int                             frames_seen = 0;
    logic [NUM_REGS-1:0][REG_W-1:0] shadow      = '0;
    logic [REG_W-1:0]               wr_vals [NUM_REGS];

    reg_display_top u_dut (
        .clock      (clock),
        .resetn     (resetn),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .pix        (pix),
        .pix_valid  (pix_valid),
        .pix_ready  (pix_ready),
        .frame_done (frame_done)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // Text character to font code, hex digits in either case
    function automatic glyph_code_t char_code(input byte ch);
        case (ch)
            "G":     return GLYPH_G;
            "I":     return GLYPH_I;
            "L":     return GLYPH_L;
            "N":     return GLYPH_N;
            "R":     return GLYPH_R;
            "S":     return GLYPH_S;
            "T":     return GLYPH_T;
            ":":     return GLYPH_COLON;
            " ":     return GLYPH_SPACE;
            default: return (ch <= "9") ? glyph_code_t'(ch - "0")
                                        : glyph_code_t'((ch | 8'h20) - "a" + 10);
        endcase
    endfunction

    function automatic pixel_t expected_pixel(input int idx,
                                              input logic [NUM_REGS-1:0][REG_W-1:0] regs);
        string       text;
        int          chr;
        int          col;
        int          text_row;
        int          px;
        int          py;
        logic [63:0] glyph_bits;
        color_t      ink;
        pixel_t      p;
        chr = idx / (GLYPH_DIM * GLYPH_DIM);
        px  = idx % GLYPH_DIM;
        py  = (idx / GLYPH_DIM) % GLYPH_DIM;
        if (chr < TITLE_LEN) begin
            text = TITLE_TEXT;
            col  = chr;
            ink  = TITLE_COLOR;
            p.x  = 10'(TITLE_X0 + col * CHAR_PITCH + px);
            p.y  = 9'(TITLE_Y0 + py);
        end else begin
            text_row = (chr - TITLE_LEN) / LINE_LEN;
            col      = (chr - TITLE_LEN) % LINE_LEN;
            text     = $sformatf("R%0d: %08h", text_row, regs[text_row]);
            ink      = TEXT_COLOR;
            p.x      = 10'(TEXT_X0 + col * CHAR_PITCH + px);
            p.y      = 9'(TEXT_Y0 + text_row * LINE_PITCH + py);
        end
        case (char_code(text[col]))
            `include "glyph_table.svh"
            default: glyph_bits = '0;
        endcase
        p.color = glyph_bits[py * GLYPH_DIM + GLYPH_DIM - 1 - px] ? ink : BG_COLOR;
        return p;
    endfunction

    always @(posedge clock) begin
        pix_ready <= (($random(seed) & 3) != 0);  // Roughly one stall in four
    end

    always @(posedge clock) begin : compare
        pixel_t exp_pix;
        logic   exp_done;
        if (resetn && pix_valid && pix_ready) begin
            exp_pix  = expected_pixel(acc_idx, shadow);
            exp_done = (acc_idx == FRAME_PIX - 1);
            assert (pix == exp_pix) else begin
                pix_errors++;
                $display("[FAIL] pix at acceptance %0d: got %h expected %h",
                         acc_idx, pix, exp_pix);
            end
            assert (frame_done == exp_done) else begin
                pix_errors++;
                $display("[FAIL] frame_done at acceptance %0d: got %h expected %h",
                         acc_idx, frame_done, exp_done);
            end
            if (exp_done) begin
                acc_idx = 0;
                frames_seen++;
            end else begin
                acc_idx++;
            end
        end
        // Aligned write lands at the end of the access phase
        if (apb_req.psel && apb_req.penable && apb_req.pwrite && apb_req.paddr[1:0] == 2'b00) begin
            shadow[apb_req.paddr[4:2]] = apb_req.pwdata;
        end
    end

    task automatic apb_transfer(input logic write, input logic [4:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        @(posedge clock);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge clock);
        apb_req.penable <= 1'b1;
        @(posedge clock);  // Zero-wait slave, access ends here
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        apb_req <= '0;
    endtask

    task automatic readback_regs();
        logic [31:0] rdata;
        logic        err;
        for (int i = 0; i < NUM_REGS; i++) begin
            apb_transfer(1'b0, 5'(4 * i), '0, rdata, err);
            assert (rdata == wr_vals[i] && !err) else begin
                apb_errors++;
                $display("[FAIL] prdata of R%0d: got %h expected %h, pslverr %h",
                         i, rdata, wr_vals[i], err);
            end
        end
    endtask

    task automatic wait_frame_end();
        do begin
            @(posedge clock);
        end while (!frame_done);
    endtask

    task automatic finish_run(input bit timed_out);
        $display("Frames %0d, pixel errors %0d, APB errors %0d, property errors %0d",
                 frames_seen, pix_errors, apb_errors, u_dut.u_props.prop_errors);
        if (!timed_out && pix_errors + apb_errors + u_dut.u_props.prop_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    initial begin : stimulus
        logic [31:0] rdata;
        logic        err;
        resetn    = 1'b0;
        apb_req   = '0;
        pix_ready = 1'b0;
        wr_vals   = '{default: '0};
        repeat (10) @(posedge clock);
        resetn <= 1'b1;
        readback_regs();   // Cleared by reset
        wait_frame_end();  // First frame, all digits zero
        for (int i = 0; i < NUM_REGS; i++) begin
            wr_vals[i] = $random(seed);
            apb_transfer(1'b1, 5'(4 * i), wr_vals[i], rdata, err);
            assert (!err) else begin
                apb_errors++;
                $display("[FAIL] pslverr on write to R%0d: got %h expected 0", i, err);
            end
        end
        readback_regs();
        wait_frame_end();  // Second frame shows the new digits
        apb_transfer(1'b1, 5'h06, 32'hdead_beef, rdata, err);
        assert (err) else begin
            apb_errors++;
            $display("[FAIL] pslverr on misaligned write: got %h expected 1", err);
        end
        readback_regs();
        wait_frame_end();
        @(posedge clock);
        assert (frames_seen == 3) else begin
            pix_errors++;
            $display("Expected three complete frames but counted %0d", frames_seen);
        end
        finish_run(1'b0);
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Timeout: frames did not complete within %0d cycles", WATCHDOG_CYCLES);
        finish_run(1'b1);
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+include
logic/disp_pkg.sv
logic/reg_bank_apb.sv
logic/glyph_scan_counter.sv
logic/draw_sequencer.sv
logic/text_layout.sv
logic/glyph_raster.sv
logic/reg_display_top.sv
testbench/reg_display_properties.sv
testbench/reg_display_tb.sv
